// ==== Makefile ====
# Verilator build for the main CPU board testbench

VERILATOR  ?= verilator
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing -j 0
TOP        ?= main_board_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

// ==== build.f ====
logic/main_pkg.sv
logic/main_decode.sv
logic/main_ctrl_regs.sv
logic/main_wait.sv
logic/main_irq.sv
logic/main_ram.sv
logic/main_rdmux.sv
logic/main_board.sv
dv/main_board_sva.sv
dv/main_board_tb.sv

// ==== dv/main_board_sva.sv ====
// Main board bus assertions
// Chip selects against the memory map, the wait stall rule and
// the reset values of the control outputs

`timescale 1ns/1ns
`default_nettype none

module main_board_sva (
    input logic        clk,
    input logic        rst,
    input logic [15:0] addr,
    input logic        mreq_n,
    input logic        rfsh_n,
    input logic        rom_cs,
    input logic        char_cs,
    input logic        rom_ok,
    input logic        char_busy,
    input logic        wait_n,
    input logic        int_n,
    input logic        cpu_rst_n,
    input logic        flip,
    input logic        sres_b,
    input logic [7:0]  snd_latch,
    input logic [7:0]  scrposv,
    input logic        chon,
    input logic        scron,
    input logic        objon,
    input logic [2:0]  obj_bank
);

    logic bus_valid;
    logic rom_area;    // 0000-BFFF
    logic char_area;   // D000-D7FF

    assign bus_valid = rfsh_n && !mreq_n;
    assign rom_area  = bus_valid && (addr[15:14] != 2'b11);
    assign char_area = bus_valid && (addr[15:11] == 5'b11010);

    // Disjoint areas, so at most one select is high
    cs_onehot: assert property (@(posedge clk)
        (rom_cs == rom_area) && (char_cs == char_area))
        else $error("rom_cs or char_cs does not follow the memory map");

    wait_rule: assert property (@(posedge clk) disable iff (rst)
        wait_n == !((rom_area && !rom_ok) || (char_area && char_busy)))
        else $error("wait_n does not follow the stall condition");

    // Control outputs parked while reset is held
    reset_vals: assert property (@(posedge clk) rst |->
        (!flip && sres_b && snd_latch == 8'd0 && scrposv == 8'd0 && !chon
         && !scron && !objon && obj_bank == 3'd0 && int_n && !cpu_rst_n))
        else $error("control output left its reset value during reset");

endmodule

bind main_board main_board_sva sva_i (.*);

`default_nettype wire

// ==== dv/main_board_tb.sv ====
// Main board testbench
// Plays the CPU on the bus, models the memory map, registers, RAM
// and cabinet port, and compares the board responses with the model

`timescale 1ns/1ns
`default_nettype none

module main_board_tb
    import main_pkg::*;
();

    localparam int N_OPS      = 400;                      // Bus operations, rough upper bound
    localparam int TIMEOUT_NS = (N_OPS * 16 + 64) * 4;

    logic        clk, rst, cen;
    logic [15:0] addr;
    logic [7:0]  cpu_dout, cpu_din;
    logic        mreq_n, rfsh_n, wr_n, iorq_n, m1_n;
    logic        wait_n, int_n, cpu_rst_n;
    logic [8:0]  v;
    logic        lhbl, lvbl;
    logic [7:0]  char_dout, scrposv, snd_latch, ram_dout, rom_data, dipsw_a, dipsw_b;
    logic        char_busy, char_cs, flip, chon, scron, objon, sres_b, okout;
    logic [1:0]  scrposh_cs, start_button, coin_input;
    logic [2:0]  obj_bank;
    logic [6:0]  joystick1, joystick2;
    logic [12:0] obj_ab;
    logic        blcnten, rom_ok, rom_cs;
    logic [ROM_AW-1:0] rom_addr;

    // Model state
    logic [7:0]  ram_model [8192];
    logic [7:0]  m_snd, m_scrv;
    logic [1:0]  m_bank;
    logic [2:0]  m_objbank;
    logic        m_flip, m_sres_b, m_chon, m_scron, m_objon;
    logic [15:0] lfsr_state = 16'd28626;
    logic [7:0]  exp_din;
    logic [15:0] wr_list [32];
    event        sample_ev;

    main_board main_board_i (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(negedge clk) cen <= ~cen;

    ////////////////////////////////////////////////////////////
    // Helpers

    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b)
            lfsr_state = lfsr_state ^ 16'hB400;   // Galois taps
        return b;
    endfunction

    function automatic logic [7:0] rand_byte();
        logic [7:0] r;
        r = 8'd0;
        for (int k = 0; k < 8; k++)
            r = {r[6:0], lfsr_bit()};
        return r;
    endfunction

    // 32 KB fixed area, then bank b of four 16 KB banks above it
    function automatic logic [ROM_AW-1:0] expected_rom_addr(input logic [15:0] a,
                                                            input logic [1:0]  b);
        if (!a[15])
            return ROM_AW'(a[14:0]);
        return ROM_AW'(32'h8000 + 32'(b) * 32'h4000 + 32'(a[13:0]));
    endfunction

    function automatic logic [7:0] cabinet_byte(input logic [2:0] i);
        case (i)
            3'd0:    return {coin_input, 2'b11, ~lvbl, 1'b1, start_button};
            3'd1:    return {1'b1, joystick1};
            3'd2:    return {1'b1, joystick2};
            3'd3:    return dipsw_a;
            3'd4:    return dipsw_b;
            default: return 8'hff;
        endcase
    endfunction

    // Expected CPU read data for a memory read at a
    function automatic logic [7:0] expected_read(input logic [15:0] a);
        if (a[15:14] != 2'b11)
            return rom_data;
        if (a[15:13] == 3'b111)
            return ram_model[a[12:0]];
        case (a[12:11])
            2'b00:   return cabinet_byte(a[2:0]);
            2'b10:   return char_dout;
            default: return 8'hff;
        endcase
    endfunction

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %0h expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "check failed");
        end
    endtask

    task automatic cen_tick();
        @(posedge clk);
        while (!cen)
            @(posedge clk);
        @(negedge clk);
    endtask

    task automatic bus_idle();
        mreq_n = 1'b1;
        wr_n   = 1'b1;
        rfsh_n = 1'b1;
        iorq_n = 1'b1;
        m1_n   = 1'b1;
    endtask

    task automatic check_regs();
        check_value(32'(snd_latch), 32'(m_snd), "snd_latch");
        check_value(32'(scrposv), 32'(m_scrv), "scrposv");
        check_value(32'({flip, sres_b, chon, scron, objon}),
                    32'({m_flip, m_sres_b, m_chon, m_scron, m_objon}), "control bits");
        check_value(32'(obj_bank), 32'(m_objbank), "obj_bank");
    endtask

    task automatic cpu_write(input logic [15:0] a, input logic [7:0] d, input int ticks);
        addr = a;
        cpu_dout = d;
        mreq_n = 1'b0;
        wr_n = 1'b0;
        #1;
        check_value(32'(okout), 32'(a == 16'hC806), "okout strobe");
        check_value(32'(scrposh_cs), 32'({a == 16'hD801, a == 16'hD800}), "scrposh_cs");
        repeat (ticks) cen_tick();
        case (a)
            16'hC800: m_snd = d;
            16'hC804: {m_chon, m_flip, m_sres_b, m_bank} = {d[7], d[6], ~d[5], d[3:2]};
            16'hD802: m_scrv = d;
            16'hD806: {m_objon, m_scron, m_objbank} = {d[5], d[4], d[2:0]};
            default: ;
        endcase
        if (a[15:13] == 3'b111 && !blcnten)
            ram_model[a[12:0]] = d;
        check_regs();
        bus_idle();
        #1;
        check_value(32'({okout, scrposh_cs}), 32'd0, "strobes after write");
        @(negedge clk);
    endtask

    task automatic cpu_read(input logic [15:0] a, input int ticks);
        addr = a;
        mreq_n = 1'b0;
        wr_n = 1'b1;
        repeat (ticks) cen_tick();
        #1;
        check_value(32'({rom_cs, char_cs}),
                    32'({a[15:14] != 2'b11, a[15:11] == 5'b11010}), "chip selects");
        exp_din = expected_read(a);
        -> sample_ev;
        @(negedge clk);
        bus_idle();
    endtask

    // Compare process for read data
    initial begin
        forever begin
            @(sample_ev);
            check_value(32'(cpu_din), 32'(exp_din), "cpu_din");
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("TEST FAILED");
        $fatal(1, "watchdog expired, the run did not finish in time");
    end

    ////////////////////////////////////////////////////////////
    // Stimulus

    initial begin
        logic [15:0] reg_addrs [6];
        logic [15:0] a;
        logic [7:0]  b;
        int          n;
        reg_addrs = '{16'hC800, 16'hC804, 16'hD802, 16'hD800, 16'hD801, 16'hD806};
        rst = 1'b1;
        cen = 1'b0;
        addr = 16'd0;
        cpu_dout = 8'd0;
        bus_idle();
        v = 9'd0;
        lhbl = 1'b1;
        lvbl = 1'b1;
        char_dout = 8'h5a;
        char_busy = 1'b0;
        joystick1 = 7'h7f;
        joystick2 = 7'h7f;
        start_button = 2'b11;
        coin_input = 2'b11;
        obj_ab = 13'd0;
        blcnten = 1'b0;
        rom_data = 8'd0;
        rom_ok = 1'b1;
        dipsw_a = 8'hff;
        dipsw_b = 8'hff;
        {m_snd, m_scrv, m_bank, m_objbank} = '0;
        {m_flip, m_chon, m_scron, m_objon} = '0;
        m_sres_b = 1'b1;
        repeat (8) @(negedge clk);
        rst = 1'b0;

        // 1. Reset values, CPU reset released on the second clock
        @(negedge clk);
        check_value(32'(cpu_rst_n), 32'd0, "cpu_rst_n one clock after reset");
        @(negedge clk);
        check_value(32'(cpu_rst_n), 32'd1, "cpu_rst_n release");
        @(negedge clk);
        check_regs();
        check_value(32'({int_n, wait_n, okout}), 32'b110, "int_n wait_n okout");

        // 2. Register writes, OK strobe and scroll strobes included
        for (int i = 0; i < 40; i++) begin
            b = rand_byte();
            cpu_write(reg_addrs[int'(b) % 6], rand_byte(), 1);
            cpu_write(i[0] ? 16'hC806 : 16'hC804, rand_byte(), 1);
        end

        // 3. ROM reads with stall, bank changed every eight reads
        for (int i = 0; i < 48; i++) begin
            if (i % 8 == 0)
                cpu_write(16'hC804, rand_byte(), 1);
            a = {rand_byte(), rand_byte()};
            if (a[15:14] == 2'b11)
                a = a - 16'h4000;
            rom_data = rand_byte();
            rom_ok = 1'b0;
            addr = a;
            mreq_n = 1'b0;
            #1;
            check_value(32'(wait_n), 32'd0, "wait_n during ROM stall");
            check_value(32'(rom_addr), 32'(expected_rom_addr(a, m_bank)), "rom_addr");
            @(negedge clk);
            rom_ok = 1'b1;
            #1;
            check_value(32'(wait_n), 32'd1, "wait_n after rom_ok");
            @(negedge clk);
            cpu_read(a, 1);
        end

        // 4. Work RAM write, read back, then object engine window
        for (int i = 0; i < 32; i++) begin
            b = rand_byte();
            wr_list[i] = {3'b111, b[4:0], rand_byte()};
            cpu_write(wr_list[i], rand_byte(), 2);
        end
        for (int i = 0; i < 32; i++)
            cpu_read(wr_list[i], 2);
        blcnten = 1'b1;
        for (int i = 0; i < 8; i++) begin
            obj_ab = wr_list[31 - i][12:0];
            cpu_write(wr_list[i], rand_byte(), 2);
            repeat (2) @(negedge clk);
            check_value(32'(ram_dout), 32'(ram_model[obj_ab]), "ram_dout during blcnten");
        end
        blcnten = 1'b0;
        for (int i = 0; i < 8; i++)
            cpu_read(wr_list[i], 2);

        // 5. Input port, unmapped reads and character RAM stall
        for (int i = 0; i < 4; i++) begin
            b = rand_byte();
            {coin_input, start_button, lvbl} = b[4:0];
            b = rand_byte();
            joystick1 = b[6:0];
            b = rand_byte();
            joystick2 = b[6:0];
            dipsw_a = rand_byte();
            dipsw_b = rand_byte();
            for (int k = 0; k < 8; k++)
                cpu_read(16'hC000 + 16'(k), 1);
            cpu_read(16'hC801, 1);
            cpu_read(16'hD805, 1);
        end
        lvbl = 1'b1;
        char_busy = 1'b1;
        addr = 16'hD123;
        mreq_n = 1'b0;
        #1;
        check_value(32'(wait_n), 32'd0, "wait_n during char busy");
        @(negedge clk);
        char_busy = 1'b0;
        cpu_read(16'hD123, 1);

        // 6. Interrupt, clear anything left from the port test
        repeat (4) cen_tick();
        iorq_n = 1'b0;
        m1_n = 1'b0;
        cen_tick();
        bus_idle();
        check_value(32'(int_n), 32'd1, "int_n after initial acknowledge");
        mreq_n = 1'b0;
        rfsh_n = 1'b0;
        for (int i = 0; i < 20; i++) begin
            b = rand_byte();
            v = {1'b0, i[0] ? 3'd5 : 3'd1, b[4:0]};
            addr = {rand_byte(), rand_byte()};
            cen_tick();
            check_value(32'(int_n), 32'd1, "int_n in refresh sweep");
            check_value(32'({rom_cs, char_cs}), 32'd0, "chip selects in refresh");
        end
        bus_idle();
        for (int f = 0; f < 6; f++) begin
            if (f[0])
                lvbl = 1'b0;                          // Vertical blank
            else
                v = {1'b0, 3'd3, 5'd0};               // Mid-frame band
            n = 0;
            while (int_n && n < 4) begin
                cen_tick();
                n++;
            end
            check_value(32'(int_n), 32'd0, "int_n after request drop");
            lvbl = 1'b1;
            v = 9'd0;
            repeat (8) begin
                cen_tick();
                check_value(32'(int_n), 32'd0, "int_n held before acknowledge");
            end
            iorq_n = 1'b0;
            m1_n = 1'b0;
            cen_tick();
            bus_idle();
            check_value(32'(int_n), 32'd1, "int_n after acknowledge");
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== logic/main_board.sv ====
// Main CPU board logic
// Everything around the external 8-bit CPU: memory map, control
// registers, banked ROM address, shared work RAM, wait and interrupt
// generation, and the read data path back to the CPU.
// Also releases the CPU reset through a two-flop synchronizer.

`timescale 1ns/1ns
`default_nettype none

module main_board
    import main_pkg::*;
#(
    parameter int RAM_AW = 13
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cen,
    // CPU bus
    input  logic [15:0]       addr,
    input  logic [7:0]        cpu_dout,
    input  logic              mreq_n,
    input  logic              rfsh_n,
    input  logic              wr_n,
    input  logic              iorq_n,
    input  logic              m1_n,
    output logic [7:0]        cpu_din,
    output logic              wait_n,
    output logic              int_n,
    output logic              cpu_rst_n,
    // Video timing
    input  logic [8:0]        v,
    input  logic              lhbl,
    input  logic              lvbl,
    // Characters and scroll
    input  logic [7:0]        char_dout,
    input  logic              char_busy,
    output logic              char_cs,
    output logic [7:0]        scrposv,
    output logic [1:0]        scrposh_cs,
    output logic              flip,
    output logic              chon,
    output logic              scron,
    output logic              objon,
    output logic [2:0]        obj_bank,
    // Sound
    output logic              sres_b,
    output logic [7:0]        snd_latch,
    output logic              okout,
    // Cabinet
    input  logic [6:0]        joystick1,
    input  logic [6:0]        joystick2,
    input  logic [1:0]        start_button,
    input  logic [1:0]        coin_input,
    input  logic [7:0]        dipsw_a,
    input  logic [7:0]        dipsw_b,
    // Object engine bus sharing
    input  logic [12:0]       obj_ab,
    input  logic              blcnten,
    output logic [7:0]        ram_dout,
    // ROM
    input  logic [7:0]        rom_data,
    input  logic              rom_ok,
    output logic              rom_cs,
    output logic [ROM_AW-1:0] rom_addr
);

    main_region_e region;
    main_wreg_e   wreg;
    logic [1:0]   bank;
    logic [1:0]   rst_sync;

    ////////////////////////////////////////////////////////////
    // CPU reset release

    always_ff @(posedge clk, posedge rst) begin
        if (rst)
            rst_sync <= 2'b00;
        else
            rst_sync <= {rst_sync[0], 1'b1};
    end

    assign cpu_rst_n = rst_sync[1];

    ////////////////////////////////////////////////////////////
    // ROM address, 32 KB fixed then four 16 KB banks

    always_comb begin
        rom_addr[13:0] = addr[13:0];
        if (!addr[15])
            rom_addr[ROM_AW-1:14] = {2'b00, addr[14]};
        else
            rom_addr[ROM_AW-1:14] = 3'b010 + {1'b0, bank};
    end

    ////////////////////////////////////////////////////////////
    // Blocks

    main_decode u_decode (
        .addr       (addr),
        .mreq_n     (mreq_n),
        .rfsh_n     (rfsh_n),
        .wr_n       (wr_n),
        .region     (region),
        .wreg       (wreg),
        .rom_cs     (rom_cs),
        .char_cs    (char_cs),
        .scrposh_cs (scrposh_cs)
    );

    main_ctrl_regs u_ctrl_regs (
        .clk       (clk),
        .rst       (rst),
        .cen       (cen),
        .wreg      (wreg),
        .cpu_dout  (cpu_dout),
        .flip      (flip),
        .sres_b    (sres_b),
        .snd_latch (snd_latch),
        .scrposv   (scrposv),
        .chon      (chon),
        .scron     (scron),
        .objon     (objon),
        .obj_bank  (obj_bank),
        .bank      (bank),
        .okout     (okout)
    );

    main_wait u_wait (
        .rom_cs    (rom_cs),
        .rom_ok    (rom_ok),
        .char_cs   (char_cs),
        .char_busy (char_busy),
        .wait_n    (wait_n)
    );

    main_irq u_irq (
        .clk    (clk),
        .rst    (rst),
        .cen    (cen),
        .v      (v[7:5]),   // Only the mid-frame band matters
        .lvbl   (lvbl),
        .iorq_n (iorq_n),
        .m1_n   (m1_n),
        .int_n  (int_n)
    );

    main_ram #(
        .RAM_AW (RAM_AW)
    ) u_ram (
        .clk      (clk),
        .cen      (cen),
        .addr     (addr[RAM_AW-1:0]),
        .cpu_dout (cpu_dout),
        .region   (region),
        .wr_n     (wr_n),
        .obj_ab   (obj_ab[RAM_AW-1:0]),
        .blcnten  (blcnten),
        .ram_dout (ram_dout)
    );

    main_rdmux u_rdmux (
        .addr         (addr[2:0]),
        .region       (region),
        .ram_dout     (ram_dout),
        .char_dout    (char_dout),
        .rom_data     (rom_data),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .lvbl         (lvbl),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cpu_din      (cpu_din)
    );

endmodule

`default_nettype wire

// ==== logic/main_ctrl_regs.sv ====
// Main CPU control registers
// Sound latch, ROM bank and flip, vertical scroll and graphics
// layer enables, written through the decoded register target.
// The OK strobe is passed on without storage.

`timescale 1ns/1ns
`default_nettype none

module main_ctrl_regs
    import main_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  main_wreg_e  wreg,
    input  logic [7:0]  cpu_dout,
    output logic        flip,
    output logic        sres_b,
    output logic [7:0]  snd_latch,
    output logic [7:0]  scrposv,
    output logic        chon,
    output logic        scron,
    output logic        objon,
    output logic [2:0]  obj_bank,
    output logic [1:0]  bank,
    output logic        okout
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            flip      <= 1'b0;
            sres_b    <= 1'b1;   // Sound CPU running
            snd_latch <= 8'd0;
            scrposv   <= 8'd0;
            chon      <= 1'b0;
            scron     <= 1'b0;
            objon     <= 1'b0;
            obj_bank  <= 3'd0;
            bank      <= 2'd0;
        end else if (cen) begin
            case (wreg)
                W_SND:  snd_latch <= cpu_dout;
                W_BANK: begin
                    chon   <= cpu_dout[7];
                    flip   <= cpu_dout[6];
                    sres_b <= ~cpu_dout[5];    // Inverted on the board
                    bank   <= cpu_dout[3:2];
                    // Bits 1:0 drive coin counters, not modelled
                end
                W_SCRV: scrposv <= cpu_dout;
                W_GFX: begin
                    objon    <= cpu_dout[5];
                    scron    <= cpu_dout[4];
                    obj_bank <= cpu_dout[2:0];
                end
                default: ;
            endcase
        end
    end

    assign okout = (wreg == W_OK);

endmodule

`default_nettype wire

// ==== logic/main_decode.sv ====
// Main CPU memory map decoder
// Turns the CPU address and bus strobes into a read/write region,
// a write register target and the chip selects that leave the board.
// Refresh and idle cycles decode to nothing.

`timescale 1ns/1ns
`default_nettype none

module main_decode
    import main_pkg::*;
(
    input  logic [15:0]   addr,
    input  logic          mreq_n,
    input  logic          rfsh_n,
    input  logic          wr_n,
    output main_region_e  region,
    output main_wreg_e    wreg,
    output logic          rom_cs,
    output logic          char_cs,
    output logic [1:0]    scrposh_cs
);

    logic bus_valid;
    logic reg_wr;   // Register write slot, A[3] low

    assign bus_valid = rfsh_n && !mreq_n;
    assign reg_wr    = !wr_n && !addr[3];

    always_comb begin
        region = REG_NONE;
        wreg   = W_NONE;
        if (bus_valid) begin
            casez (addr[15:13])
                3'b0??, 3'b10?: region = REG_ROM;  // 48 KB
                3'b110: begin
                    case (addr[12:11])
                        2'b00: region = REG_IN;    // C000
                        2'b01: if (reg_wr) begin   // C800
                            case (addr[2:0])
                                3'b000:  wreg = W_SND;
                                3'b100:  wreg = W_BANK;
                                3'b110:  wreg = W_OK;
                                default: wreg = W_NONE;
                            endcase
                        end
                        2'b10: region = REG_CHAR;  // D000
                        default: if (reg_wr) begin // D800
                            case (addr[2:0])
                                3'b000:  wreg = W_SCRH0;
                                3'b001:  wreg = W_SCRH1;
                                3'b010:  wreg = W_SCRV;
                                3'b110:  wreg = W_GFX;
                                default: wreg = W_NONE;
                            endcase
                        end
                    endcase
                end
                default: region = REG_RAM;         // E000-FFFF
            endcase
        end
    end

    assign rom_cs     = (region == REG_ROM);
    assign char_cs    = (region == REG_CHAR);
    // Scroll position strobes go straight to the scroll layer
    assign scrposh_cs = {wreg == W_SCRH1, wreg == W_SCRH0};

endmodule

`default_nettype wire

// ==== logic/main_irq.sv ====
// Vertical interrupt generator
// The request level is high during the active frame outside the
// mid-frame band of V. Its falling edge pulls int_n low, and the
// CPU interrupt acknowledge cycle releases it.

`timescale 1ns/1ns
`default_nettype none

module main_irq
    import main_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        cen,
    input  logic [7:5]  v,
    input  logic        lvbl,
    input  logic        iorq_n,
    input  logic        m1_n,
    output logic        int_n
);

    logic int_rqb;        // Sampled request level
    logic int_rqb_last;
    logic irq_ack;
    logic rqb_fall;

    assign irq_ack  = !iorq_n && !m1_n;
    assign rqb_fall = int_rqb_last && !int_rqb;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            int_rqb      <= 1'b0;
            int_rqb_last <= 1'b0;
            int_n        <= 1'b1;
        end else if (cen) begin
            int_rqb      <= lvbl && (v != IRQ_LINE);
            int_rqb_last <= int_rqb;
            if (irq_ack)
                int_n <= 1'b1;   // Acknowledge wins over a new edge
            else if (rqb_fall)
                int_n <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== logic/main_pkg.sv ====
// Main board shared definitions
// Decoded bus regions, register write targets and board constants
// used across the main CPU board logic

`default_nettype none

package main_pkg;

    // Read/write region seen by the CPU bus
    typedef enum logic [2:0] {
        REG_NONE,
        REG_ROM,
        REG_RAM,
        REG_IN,   // Cabinet input port
        REG_CHAR  // Character RAM
    } main_region_e;

    // Write-only register targets in the C800 and D800 blocks
    typedef enum logic [2:0] {
        W_NONE,
        W_SND,    // Sound latch
        W_BANK,   // ROM bank, flip, sound reset
        W_OK,
        W_SCRH0,  // Horizontal scroll low
        W_SCRH1,  // Horizontal scroll high
        W_SCRV,
        W_GFX     // Layer enables and object bank
    } main_wreg_e;

    localparam int ROM_AW = 17;  // 32 KB fixed plus four 16 KB banks

    // V[7:5] value for the mid-frame interrupt point
    localparam logic [2:0] IRQ_LINE = 3'd3;

endpackage

`default_nettype wire

// ==== logic/main_ram.sv ====
// Shared work RAM
// Single-port synchronous RAM for the CPU. While blcnten is high
// the object engine owns the address and CPU writes are dropped.

`timescale 1ns/1ns
`default_nettype none

module main_ram
    import main_pkg::*;
#(
    parameter int RAM_AW = 13
) (
    input  logic              clk,
    input  logic              cen,
    input  logic [RAM_AW-1:0] addr,
    input  logic [7:0]        cpu_dout,
    input  main_region_e      region,
    input  logic              wr_n,
    input  logic [RAM_AW-1:0] obj_ab,
    input  logic              blcnten,
    output logic [7:0]        ram_dout
);

    logic [7:0]        mem [2**RAM_AW];
    logic [RAM_AW-1:0] ram_addr;
    logic              ram_we;

    assign ram_addr = blcnten ? obj_ab : addr;   // Object engine window
    assign ram_we   = cen && !blcnten && !wr_n && (region == REG_RAM);

    always_ff @(posedge clk) begin
        if (ram_we)
            mem[ram_addr] <= cpu_dout;
        ram_dout <= mem[ram_addr];   // Read every clock
    end

endmodule

`default_nettype wire

// ==== logic/main_rdmux.sv ====
// CPU read data path
// Builds the cabinet input byte and picks the byte returned to the
// CPU from RAM, character RAM, ROM or the input port. Anything else
// reads as FF.

`timescale 1ns/1ns
`default_nettype none

module main_rdmux
    import main_pkg::*;
(
    input  logic [2:0]    addr,
    input  main_region_e  region,
    input  logic [7:0]    ram_dout,
    input  logic [7:0]    char_dout,
    input  logic [7:0]    rom_data,
    input  logic [6:0]    joystick1,
    input  logic [6:0]    joystick2,
    input  logic [1:0]    start_button,
    input  logic [1:0]    coin_input,
    input  logic          lvbl,
    input  logic [7:0]    dipsw_a,
    input  logic [7:0]    dipsw_b,
    output logic [7:0]    cpu_din
);

    logic [7:0] cabinet;

    always_comb begin
        case (addr)
            3'd0:    cabinet = {coin_input, 2'b11, ~lvbl, 1'b1, start_button};
            3'd1:    cabinet = {1'b1, joystick1};
            3'd2:    cabinet = {1'b1, joystick2};
            3'd3:    cabinet = dipsw_a;
            3'd4:    cabinet = dipsw_b;
            default: cabinet = 8'hff;
        endcase
    end

    always_comb begin
        case (region)
            REG_RAM:  cpu_din = ram_dout;
            REG_CHAR: cpu_din = char_dout;
            REG_ROM:  cpu_din = rom_data;
            REG_IN:   cpu_din = cabinet;
            default:  cpu_din = 8'hff;   // Open bus
        endcase
    end

endmodule

`default_nettype wire

// ==== logic/main_wait.sv ====
// Main CPU wait generator
// Holds wait_n low while a ROM fetch has no data from the SDRAM
// yet, or while the character RAM is taken by the video scan.
// The CPU keeps its bus steady for the whole stall.

`timescale 1ns/1ns
`default_nettype none

module main_wait (
    input  logic rom_cs,
    input  logic rom_ok,
    input  logic char_cs,
    input  logic char_busy,
    output logic wait_n
);

    ////////////////////////////////////////////////////////////
    // Stall sources

    logic rom_stall;
    logic char_stall;

    // SDRAM slot not served yet
    assign rom_stall  = rom_cs && !rom_ok;

    // Video side owns the character RAM this cycle
    assign char_stall = char_cs && char_busy;

    ////////////////////////////////////////////////////////////
    // Wait line to the CPU

    // Combinational, so the CPU sees it in the same cycle
    assign wait_n = !(rom_stall || char_stall);

endmodule

`default_nettype wire
